// ==== logic/dir26_2.hex ====
// One 5-bit two's complement step per entry, 16 entries per line from address 0
09 09 09 09 09 09 09 09 09 09 09 09 09 09 09 08
08 08 08 08 08 08 08 08 08 08 08 08 08 07 07 07
07 07 07 07 07 07 07 07 07 07 07 06 06 06 06 06
06 06 06 06 06 06 06 06 06 05 05 05 05 05 05 05
05 05 05 05 05 05 05 05 04 04 04 04 04 04 04 04
04 04 04 04 04 04 03 03 03 03 03 03 03 03 03 03
03 03 03 03 02 02 02 02 02 02 02 02 02 02 02 02
02 02 01 01 01 01 01 01 01 01 01 01 01 01 01 01
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 1f
1f 1f 1f 1f 1f 1f 1f 1f 1f 1f 1f 1f 1f 1e 1e 1e
1e 1e 1e 1e 1e 1e 1e 1e 1e 1e 1e 1d 1d 1d 1d 1d
1d 1d 1d 1d 1d 1d 1d 1d 1d 1c 1c 1c 1c 1c 1c 1c
1c 1c 1c 1c 1c 1c 1c 1c 1b 1b 1b 1b 1b 1b 1b 1b
1b 1b 1b 1b 1b 1b 1a 1a 1a 1a 1a 1a 1a 1a 1a 1a
1a 1a 1a 1a 19 19 19 19 19 19 19 19 19 19 19 19
19 19 18 18 18 18 18 18 18 18 18 18 18 18 18 18

// ==== project.f ====
common/dir_pkg.sv
logic/dir26_2.sv
logic/step_counter.sv
logic/offset_accum.sv
sweep/sweep_regs.sv
sweep/sweep_fsm.sv
sweep/dir_sweep.sv
tb/dir_sweep_checker.sv
tb/tb_dir_sweep.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_dir_sweep
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Run from the project root so the table image path resolves
run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

// ==== tb/tb_dir_sweep.sv ====
`timescale 1ns/10ps

module tb_dir_sweep
	import dir_pkg::*;
();

	localparam int NUM_RANDOM = 30;
	// Forty full-table sweeps with bus overhead, plus setup
	localparam int TIMEOUT_CYCLES = 40 * (TAB_DEPTH + 40) + 2000;
	localparam axil_data_t OKAY_RESP   = axil_data_t'(RESP_OKAY);
	localparam axil_data_t SLVERR_RESP = axil_data_t'(RESP_SLVERR);

	logic      clk;
	logic      arst_n;
	axil_req_t axil_req;
	axil_rsp_t axil_rsp;

	integer seed;
	int     cycles = 0;
	step_t  model_tab [TAB_DEPTH];

	dir_sweep dut0 (
		.clk      (clk),
		.arst_n   (arst_n),
		.axil_req (axil_req),
		.axil_rsp (axil_rsp)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout: run exceeded %0d cycles", TIMEOUT_CYCLES);
			$display("Simulation finished: FAIL");
			$fatal(1);
		end
	end

	task automatic check_value(input string name, input axil_data_t expected,
		input axil_data_t actual);
		if (expected !== actual) begin
			$display("mismatch %s expected %08h actual %08h", name, expected, actual);
			$display("Simulation finished: FAIL");
			$fatal(1);
		end
	endtask

	//////////////////////////////
	// Host bus tasks
	//////////////////////////////
	task automatic write_reg(input axil_addr_t addr, input axil_data_t data,
		output axil_data_t resp);
		int delay;
		@(posedge clk);
		axil_req.awvalid <= 1'b1;
		axil_req.awaddr  <= addr;
		axil_req.wvalid  <= 1'b1;
		axil_req.wdata   <= data;
		// Handshake at the edge where awready is seen
		do begin
			@(posedge clk);
		end while (!axil_rsp.awready);
		// wready rises together with awready
		check_value("write wready", 32'h1, axil_data_t'(axil_rsp.wready));
		axil_req.awvalid <= 1'b0;
		axil_req.wvalid  <= 1'b0;
		delay = $unsigned($random(seed)) % 4;
		repeat (delay) @(posedge clk);
		axil_req.bready <= 1'b1;
		do begin
			@(posedge clk);
		end while (!axil_rsp.bvalid);
		resp = axil_data_t'(axil_rsp.bresp);
		axil_req.bready <= 1'b0;
	endtask

	task automatic read_reg(input axil_addr_t addr, output axil_data_t data,
		output axil_data_t resp);
		int delay;
		@(posedge clk);
		axil_req.arvalid <= 1'b1;
		axil_req.araddr  <= addr;
		do begin
			@(posedge clk);
		end while (!axil_rsp.arready);
		axil_req.arvalid <= 1'b0;
		delay = $unsigned($random(seed)) % 4;
		repeat (delay) @(posedge clk);
		axil_req.rready <= 1'b1;
		do begin
			@(posedge clk);
		end while (!axil_rsp.rvalid);
		data = axil_rsp.rdata;
		resp = axil_data_t'(axil_rsp.rresp);
		axil_req.rready <= 1'b0;
	endtask

	//////////////////////////////
	// Model and sweep helpers
	//////////////////////////////
	function automatic axil_data_t model_result(input tab_addr_t start_addr,
		input len_t length, input pos_t base);
		int        n;
		int        s;
		pos_t      p;
		tab_addr_t a;
		n = (length == '0) ? TAB_DEPTH : int'(length);
		p = base;
		a = start_addr;
		for (int i = 0; i < n; i++) begin
			s = int'(model_tab[a]);
			// 5-bit two's complement
			if (s > 15)
				s = s - 32;
			p = p + pos_t'(s);
			a = a + 8'd1;
		end
		return {{16{p[15]}}, p};
	endfunction

	task automatic config_sweep(input string name, input tab_addr_t start_addr,
		input len_t length, input pos_t base);
		axil_data_t resp;
		write_reg(REG_START, axil_data_t'(start_addr), resp);
		check_value({name, " start resp"}, OKAY_RESP, resp);
		write_reg(REG_LEN, axil_data_t'(length), resp);
		check_value({name, " len resp"}, OKAY_RESP, resp);
		write_reg(REG_BASE, axil_data_t'(base), resp);
		check_value({name, " base resp"}, OKAY_RESP, resp);
	endtask

	task automatic wait_done(input string name);
		axil_data_t status;
		axil_data_t resp;
		status = '0;
		while (status != 32'h2) begin
			read_reg(REG_STATUS, status, resp);
			check_value({name, " status resp"}, OKAY_RESP, resp);
			if (status != 32'h2)
				check_value({name, " busy"}, 32'h1, status);
		end
	endtask

	task automatic run_sweep(input string name, input tab_addr_t start_addr,
		input len_t length, input pos_t base);
		axil_data_t data;
		axil_data_t resp;
		config_sweep(name, start_addr, length, base);
		write_reg(REG_CTRL, 32'h1, resp);
		check_value({name, " ctrl resp"}, OKAY_RESP, resp);
		wait_done(name);
		read_reg(REG_RESULT, data, resp);
		check_value({name, " result resp"}, OKAY_RESP, resp);
		check_value({name, " result"}, model_result(start_addr, length, base), data);
	endtask

	initial begin
		axil_data_t data;
		axil_data_t resp;
		tab_addr_t  r_start;
		len_t       r_len;
		pos_t       r_base;

		seed = 32'h2065c312;
		arst_n   <= 1'b0;
		axil_req <= '0;
		$readmemh(DIR_TABLE_FILE, model_tab);
		repeat (16) @(posedge clk);
		arst_n <= 1'b1;
		repeat (2) @(posedge clk);

		read_reg(REG_STATUS, data, resp);
		check_value("reset status", 32'h0, data);
		check_value("reset status resp", OKAY_RESP, resp);
		read_reg(REG_RESULT, data, resp);
		check_value("reset result", 32'h0, data);
		check_value("reset result resp", OKAY_RESP, resp);

		run_sweep("full table", 8'd0, 8'd0, 16'h1234);
		run_sweep("last entry", 8'd255, 8'd1, 16'h0100);
		run_sweep("wrap to zero", 8'd250, 8'd12, 16'hFFF0);
		run_sweep("positive overflow", 8'd0, 8'd16, 16'h7FFF);

		for (int i = 0; i < NUM_RANDOM; i++) begin
			r_start = tab_addr_t'($random(seed));
			r_len   = len_t'($random(seed));
			r_base  = pos_t'($random(seed));
			run_sweep($sformatf("random %0d", i), r_start, r_len, r_base);
		end

		// Config writes and a second start while busy
		config_sweep("lockout", 8'd10, 8'd200, 16'h0500);
		write_reg(REG_CTRL, 32'h1, resp);
		check_value("lockout ctrl resp", OKAY_RESP, resp);
		write_reg(REG_START, 32'h80, resp);
		check_value("lockout start resp", OKAY_RESP, resp);
		write_reg(REG_LEN, 32'h3, resp);
		check_value("lockout len resp", OKAY_RESP, resp);
		write_reg(REG_BASE, 32'h7000, resp);
		check_value("lockout base resp", OKAY_RESP, resp);
		write_reg(REG_CTRL, 32'h1, resp);
		check_value("lockout restart resp", OKAY_RESP, resp);
		read_reg(REG_STATUS, data, resp);
		check_value("lockout still busy", 32'h1, data);
		wait_done("lockout");
		read_reg(REG_RESULT, data, resp);
		check_value("lockout result", model_result(8'd10, 8'd200, 16'h0500), data);
		read_reg(REG_STATUS, data, resp);
		check_value("lockout no restart", 32'h2, data);
		read_reg(REG_START, data, resp);
		check_value("lockout start kept", 32'd10, data);
		read_reg(REG_LEN, data, resp);
		check_value("lockout len kept", 32'd200, data);
		read_reg(REG_BASE, data, resp);
		check_value("lockout base kept", 32'h0500, data);

		write_reg(REG_START, 32'h3C, resp);
		write_reg(REG_LEN, 32'h2A, resp);
		write_reg(REG_BASE, 32'hFFFF_BEEF, resp);
		read_reg(REG_START, data, resp);
		check_value("readback start", 32'h3C, data);
		read_reg(REG_LEN, data, resp);
		check_value("readback len", 32'h2A, data);
		read_reg(REG_BASE, data, resp);
		check_value("readback base", 32'hBEEF, data);
		read_reg(REG_CTRL, data, resp);
		check_value("readback ctrl", 32'h0, data);
		check_value("readback ctrl resp", OKAY_RESP, resp);

		write_reg(8'h20, 32'h1, resp);
		check_value("unmapped write resp", SLVERR_RESP, resp);
		read_reg(8'h20, data, resp);
		check_value("unmapped read data", 32'h0, data);
		check_value("unmapped read resp", SLVERR_RESP, resp);

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

// ==== tb/dir_sweep_checker.sv ====
`timescale 1ns/10ps

module dir_sweep_checker
	import dir_pkg::*;
(
	input logic      clk,
	input logic      arst_n,
	input axil_req_t axil_req,
	input axil_rsp_t axil_rsp,
	input logic      start,
	input logic      load,
	input logic      step,
	input logic      busy
);

	//////////////////////////////
	// AXI response channels
	//////////////////////////////
	a_bvalid_hold: assert property (@(posedge clk) disable iff (!arst_n)
		axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid)
		else $error("bvalid dropped before bready");

	a_rvalid_hold: assert property (@(posedge clk) disable iff (!arst_n)
		axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid)
		else $error("rvalid dropped before rready");

	//////////////////////////////
	// Sweep control
	//////////////////////////////
	a_load_step: assert property (@(posedge clk) disable iff (!arst_n)
		!(load && step))
		else $error("load and step high together");

	// A sweep only begins from a CTRL write with bit 0 set
	a_busy_start: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(busy) |-> start && $past(axil_req.awvalid && axil_rsp.awready
			&& axil_req.awaddr == REG_CTRL && axil_req.wdata[0]))
		else $error("busy raised without a start pulse");

endmodule

bind dir_sweep dir_sweep_checker u_checker (
	.clk      (clk),
	.arst_n   (arst_n),
	.axil_req (axil_req),
	.axil_rsp (axil_rsp),
	.start    (start),
	.load     (load),
	.step     (step),
	.busy     (u_regs.busy)
);

// ==== sweep/dir_sweep.sv ====
`timescale 1ns/10ps

module dir_sweep
	import dir_pkg::*;
(
	input  logic      clk,
	input  logic      arst_n,
	input  axil_req_t axil_req,
	output axil_rsp_t axil_rsp
);

	logic       start;
	logic       load;
	logic       step;
	logic       last;
	logic       finish;
	sweep_cfg_t cfg;
	tab_addr_t  addr;
	step_t      spo;
	pos_t       pos;

	sweep_regs u_regs (
		.clk      (clk),
		.arst_n   (arst_n),
		.axil_req (axil_req),
		.axil_rsp (axil_rsp),
		.finish   (finish),
		.pos      (pos),
		.start    (start),
		.cfg      (cfg)
	);

	sweep_fsm u_fsm (
		.clk    (clk),
		.arst_n (arst_n),
		.start  (start),
		.last   (last),
		.load   (load),
		.step   (step),
		.finish (finish)
	);

	//////////////////////////////
	// Datapath
	//////////////////////////////
	step_counter u_cnt (
		.clk        (clk),
		.arst_n     (arst_n),
		.load       (load),
		.step       (step),
		.start_addr (cfg.start_addr),
		.length     (cfg.length),
		.addr       (addr),
		.last       (last)
	);

	dir26_2 u_table (
		.a   (addr),
		.spo (spo)
	);

	offset_accum u_acc (
		.clk    (clk),
		.arst_n (arst_n),
		.load   (load),
		.step   (step),
		.base   (cfg.base),
		.offset (spo),
		.pos    (pos)
	);

endmodule

// ==== sweep/sweep_fsm.sv ====
`timescale 1ns/10ps

module sweep_fsm
	import dir_pkg::*;
(
	input  logic clk,
	input  logic arst_n,
	input  logic start,
	input  logic last,
	output logic load,
	output logic step,
	output logic finish
);

	sweep_state_t state;
	sweep_state_t state_nxt;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE: if (start) state_nxt = LOAD;
			LOAD: state_nxt = RUN;
			// Final step is taken in the cycle last is high
			RUN:  if (last) state_nxt = DONE;
			DONE: state_nxt = IDLE;
			default: state_nxt = IDLE;
		endcase
	end

	assign load   = (state == LOAD);
	assign step   = (state == RUN);
	assign finish = (state == DONE);

endmodule

// ==== sweep/sweep_regs.sv ====
`timescale 1ns/10ps

module sweep_regs
	import dir_pkg::*;
(
	input  logic       clk,
	input  logic       arst_n,
	input  axil_req_t  axil_req,
	output axil_rsp_t  axil_rsp,
	input  logic       finish,
	input  pos_t       pos,
	output logic       start,
	output sweep_cfg_t cfg
);

	logic       awready_q;
	logic       bvalid_q;
	logic [1:0] bresp_q;
	logic       arready_q;
	logic       rvalid_q;
	logic [1:0] rresp_q;
	axil_data_t rdata_q;

	logic       busy;
	logic       done;
	pos_t       result_q;
	sweep_cfg_t cfg_q;

	logic       wr_hs;
	logic       rd_hs;
	logic       wr_hit;
	logic       rd_hit;
	axil_data_t rd_word;

	assign wr_hs  = axil_req.awvalid & axil_req.wvalid & awready_q;
	assign rd_hs  = axil_req.arvalid & arready_q;
	assign wr_hit = axil_req.awaddr inside {REG_CTRL, REG_START, REG_LEN, REG_BASE,
		REG_STATUS, REG_RESULT};

	//////////////////////////////
	// Write channel
	//////////////////////////////
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			awready_q <= 1'b0;
			bvalid_q  <= 1'b0;
			bresp_q   <= RESP_OKAY;
			start     <= 1'b0;
			busy      <= 1'b0;
			done      <= 1'b0;
			result_q  <= '0;
			cfg_q     <= '0;
		end else begin
			start     <= 1'b0;
			awready_q <= axil_req.awvalid & axil_req.wvalid & ~awready_q & ~bvalid_q;

			if (wr_hs) begin
				bvalid_q <= 1'b1;
				bresp_q  <= wr_hit ? RESP_OKAY : RESP_SLVERR;
				// Config and start are locked out during a sweep
				if (!busy) begin
					case (axil_req.awaddr)
						REG_CTRL: begin
							if (axil_req.wdata[0]) begin
								start <= 1'b1;
								busy  <= 1'b1;
								done  <= 1'b0;
							end
						end
						REG_START: cfg_q.start_addr <= axil_req.wdata[TAB_AW-1:0];
						REG_LEN:   cfg_q.length     <= axil_req.wdata[LEN_W-1:0];
						REG_BASE:  cfg_q.base       <= axil_req.wdata[POS_W-1:0];
						default: ;
					endcase
				end
			end else if (bvalid_q && axil_req.bready) begin
				bvalid_q <= 1'b0;
			end

			if (finish) begin
				busy     <= 1'b0;
				done     <= 1'b1;
				result_q <= pos;
			end
		end
	end

	//////////////////////////////
	// Read channel
	//////////////////////////////
	always_comb begin
		rd_word = '0;
		rd_hit  = 1'b1;
		case (axil_req.araddr)
			REG_CTRL:   rd_word = '0;
			REG_START:  rd_word = axil_data_t'(cfg_q.start_addr);
			REG_LEN:    rd_word = axil_data_t'(cfg_q.length);
			REG_BASE:   rd_word = axil_data_t'(cfg_q.base);
			REG_STATUS: rd_word = {{(AXIL_DW-2){1'b0}}, done, busy};
			REG_RESULT: rd_word = {{(AXIL_DW-POS_W){result_q[POS_W-1]}}, result_q};
			default:    rd_hit  = 1'b0;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			arready_q <= 1'b0;
			rvalid_q  <= 1'b0;
			rresp_q   <= RESP_OKAY;
		end else begin
			arready_q <= axil_req.arvalid & ~arready_q & ~rvalid_q;
			if (rd_hs) begin
				rvalid_q <= 1'b1;
				rresp_q  <= rd_hit ? RESP_OKAY : RESP_SLVERR;
			end else if (rvalid_q && axil_req.rready) begin
				rvalid_q <= 1'b0;
			end
		end
	end

	// Sampled at the address handshake
	always_ff @(posedge clk) begin
		if (rd_hs) begin
			rdata_q <= rd_word;
		end
	end

	always_comb begin
		axil_rsp.awready = awready_q;
		axil_rsp.wready  = awready_q;
		axil_rsp.bvalid  = bvalid_q;
		axil_rsp.bresp   = bresp_q;
		axil_rsp.arready = arready_q;
		axil_rsp.rvalid  = rvalid_q;
		axil_rsp.rdata   = rdata_q;
		axil_rsp.rresp   = rresp_q;
	end

	assign cfg = cfg_q;

endmodule

// ==== logic/offset_accum.sv ====
`timescale 1ns/10ps

module offset_accum
	import dir_pkg::*;
(
	input  logic  clk,
	input  logic  arst_n,
	input  logic  load,
	input  logic  step,
	input  pos_t  base,
	input  step_t offset,
	output pos_t  pos
);

	pos_t offset_ext;

	// Sign extend the table step
	assign offset_ext = {{(POS_W-STEP_W){offset[STEP_W-1]}}, offset};

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pos <= '0;
		end else if (load) begin
			pos <= base;
		end else if (step) begin
			// Wraps modulo 2^16
			pos <= pos + offset_ext;
		end
	end

endmodule

// ==== logic/step_counter.sv ====
`timescale 1ns/10ps

module step_counter
	import dir_pkg::*;
(
	input  logic      clk,
	input  logic      arst_n,
	input  logic      load,
	input  logic      step,
	input  tab_addr_t start_addr,
	input  len_t      length,
	output tab_addr_t addr,
	output logic      last
);

	// One bit wider than the length so a 256-step pass fits
	typedef logic [LEN_W:0] remain_t;

	remain_t remain;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			addr   <= '0;
			remain <= '0;
		end else if (load) begin
			addr   <= start_addr;
			remain <= (length == '0) ? remain_t'(TAB_DEPTH) : remain_t'(length);
		end else if (step) begin
			// Address wraps modulo 256 by width
			addr   <= addr + 1'b1;
			remain <= remain - 1'b1;
		end
	end

	assign last = (remain == remain_t'(1));

endmodule

// ==== logic/dir26_2.sv ====
`timescale 1ns/10ps

module dir26_2
	import dir_pkg::*;
(
	input  tab_addr_t a,
	output step_t     spo
);

	// Signed steps from +9 at address 0 down to -8 at address 255
	step_t table_mem [TAB_DEPTH];

	initial begin
		$readmemh(DIR_TABLE_FILE, table_mem);
	end

	// Full 8-bit address covers every entry
	assign spo = table_mem[a];

endmodule

// ==== common/dir_pkg.sv ====
package dir_pkg;

	//////////////////////////////
	// Widths
	//////////////////////////////
	localparam int TAB_AW    = 8;
	localparam int TAB_DEPTH = 256;
	localparam int STEP_W    = 5;
	localparam int POS_W     = 16;
	localparam int LEN_W     = 8;
	localparam int AXIL_AW   = 8;
	localparam int AXIL_DW   = 32;

	typedef logic [TAB_AW-1:0]  tab_addr_t;
	typedef logic [STEP_W-1:0]  step_t;
	typedef logic [POS_W-1:0]   pos_t;
	// 0 stands for a full pass of 256 steps
	typedef logic [LEN_W-1:0]   len_t;
	typedef logic [AXIL_AW-1:0] axil_addr_t;
	typedef logic [AXIL_DW-1:0] axil_data_t;

	//////////////////////////////
	// Register map
	//////////////////////////////
	localparam axil_addr_t REG_CTRL   = 8'h00;
	localparam axil_addr_t REG_START  = 8'h04;
	localparam axil_addr_t REG_LEN    = 8'h08;
	localparam axil_addr_t REG_BASE   = 8'h0C;
	localparam axil_addr_t REG_STATUS = 8'h10;
	localparam axil_addr_t REG_RESULT = 8'h14;

	localparam logic [1:0] RESP_OKAY   = 2'd0;
	localparam logic [1:0] RESP_SLVERR = 2'd2;

	// Relative to the project root
	localparam string DIR_TABLE_FILE = "logic/dir26_2.hex";

	//////////////////////////////
	// Bus and config bundles
	//////////////////////////////
	typedef struct packed {
		logic       awvalid;
		axil_addr_t awaddr;
		logic       wvalid;
		axil_data_t wdata;
		logic       bready;
		logic       arvalid;
		axil_addr_t araddr;
		logic       rready;
	} axil_req_t;

	typedef struct packed {
		logic       awready;
		logic       wready;
		logic       bvalid;
		logic [1:0] bresp;
		logic       arready;
		logic       rvalid;
		axil_data_t rdata;
		logic [1:0] rresp;
	} axil_rsp_t;

	typedef struct packed {
		pos_t      base;
		len_t      length;
		tab_addr_t start_addr;
	} sweep_cfg_t;

	typedef enum logic [1:0] {
		IDLE,
		LOAD,
		RUN,
		DONE
	} sweep_state_t;

endpackage
